// ==== sources.f ====
+incdir+design
design/mipsPkg.sv
design/mipsControl.sv
design/mipsAlu.sv
design/regFile.sv
design/instrMem.sv
design/dataMem.sv
design/mipsCore.sv
design/mipsTop.sv
sim/mips_chk.sv
sim/mipsTb.sv

// ==== sim/mipsTb.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsTb;
  import mipsPkg::*;

  localparam int PROG_LEN    = 24;
  localparam int NUM_ROWS    = 22;
  localparam int RESET_IDLE  = 10;
  localparam int CYCLE_LIMIT = PROG_LEN + RESET_IDLE + NUM_ROWS + 20;

  logic       clk;
  logic       reset;
  logic       progWe;
  logic [5:0] progAddr;
  instrT      progData;
  commitT     commit;
  logic       commitValid;

  instrT  prog [0:PROG_LEN-1];
  commitT expected [0:NUM_ROWS-1];
  int     cycles = 0;

  mipsTop mipsTop_i (
    .clk         (clk),
    .reset       (reset),
    .progWe      (progWe),
    .progAddr    (progAddr),
    .progData    (progData),
    .commit      (commit),
    .commitValid (commitValid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // instruction word builders taking fields in encoding order
  function automatic instrT rType(input logic [5:0] funct, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [4:0] rd);
    instrT w;
    w.rFmt.opcode = `OP_RTYPE;
    w.rFmt.rs     = rs;
    w.rFmt.rt     = rt;
    w.rFmt.rd     = rd;
    w.rFmt.shamt  = 5'd0;
    w.rFmt.funct  = funct;
    return w;
  endfunction

  function automatic instrT iType(input logic [5:0] op, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [15:0] imm);
    instrT w;
    w.iFmt.opcode = op;
    w.iFmt.rs     = rs;
    w.iFmt.rt     = rt;
    w.iFmt.imm    = imm;
    return w;
  endfunction

  function automatic instrT jType(input logic [5:0] op, input logic [25:0] target);
    instrT w;
    w.jFmt.opcode = op;
    w.jFmt.target = target;
    return w;
  endfunction

  // expected commit rows
  function automatic commitT wbRow(input logic [31:0] pc, input logic [4:0] regAddr,
                                   input logic [31:0] regData);
    commitT c;
    c         = '0;
    c.pc      = pc;
    c.regWe   = 1'b1;
    c.regAddr = regAddr;
    c.regData = regData;
    return c;
  endfunction

  function automatic commitT storeRow(input logic [31:0] pc, input logic [31:0] memAddr,
                                      input logic [31:0] memData);
    commitT c;
    c         = '0;
    c.pc      = pc;
    c.memWe   = 1'b1;
    c.memAddr = memAddr;
    c.memData = memData;
    return c;
  endfunction

  // branches and jumps write nothing
  function automatic commitT flowRow(input logic [31:0] pc);
    commitT c;
    c    = '0;
    c.pc = pc;
    return c;
  endfunction

  task automatic fillTables();
    prog[0]  = iType(`OP_ADDI, 5'd0, 5'd1, 16'd6);
    prog[1]  = iType(`OP_ADDI, 5'd0, 5'd2, 16'hfffd);
    prog[2]  = rType(`FN_ADD, 5'd1, 5'd2, 5'd3);
    prog[3]  = rType(`FN_SUB, 5'd1, 5'd2, 5'd4);
    prog[4]  = rType(`FN_AND, 5'd1, 5'd2, 5'd5);
    prog[5]  = rType(`FN_OR, 5'd1, 5'd2, 5'd6);
    // -3 < 6 signed
    prog[6]  = rType(`FN_SLT, 5'd2, 5'd1, 5'd7);
    prog[7]  = rType(`FN_SLT, 5'd1, 5'd2, 5'd8);
    prog[8]  = iType(`OP_SW, 5'd0, 5'd4, 16'd8);
    prog[9]  = iType(`OP_LW, 5'd0, 5'd9, 16'd8);
    prog[10] = iType(`OP_BEQ, 5'd1, 5'd2, 16'd3);
    prog[11] = iType(`OP_BEQ, 5'd4, 5'd9, 16'd1);
    prog[12] = iType(`OP_ADDI, 5'd0, 5'd10, 16'd99);
    prog[13] = iType(`OP_BNE, 5'd4, 5'd9, 16'd1);
    prog[14] = iType(`OP_BNE, 5'd1, 5'd2, 16'd1);
    prog[15] = iType(`OP_ADDI, 5'd0, 5'd10, 16'd77);
    prog[16] = jType(`OP_J, 26'd18);
    prog[17] = iType(`OP_ADDI, 5'd0, 5'd10, 16'd55);
    prog[18] = jType(`OP_JAL, 26'd22);
    prog[19] = iType(`OP_ADDI, 5'd0, 5'd0, 16'd7);
    prog[20] = rType(`FN_ADD, 5'd0, 5'd1, 5'd11);
    // parks here
    prog[21] = jType(`OP_J, 26'd21);
    prog[22] = iType(`OP_ADDI, 5'd0, 5'd12, 16'hffff);
    prog[23] = rType(`FN_JR, 5'd31, 5'd0, 5'd0);

    expected[0]  = wbRow(32'h00, 5'd1, 32'd6);
    expected[1]  = wbRow(32'h04, 5'd2, 32'hfffffffd);
    expected[2]  = wbRow(32'h08, 5'd3, 32'd3);
    expected[3]  = wbRow(32'h0c, 5'd4, 32'd9);
    expected[4]  = wbRow(32'h10, 5'd5, 32'd4);
    expected[5]  = wbRow(32'h14, 5'd6, 32'hffffffff);
    expected[6]  = wbRow(32'h18, 5'd7, 32'd1);
    expected[7]  = wbRow(32'h1c, 5'd8, 32'd0);
    expected[8]  = storeRow(32'h20, 32'd8, 32'd9);
    expected[9]  = wbRow(32'h24, 5'd9, 32'd9);
    expected[10] = flowRow(32'h28);
    expected[11] = flowRow(32'h2c);
    expected[12] = flowRow(32'h34);
    expected[13] = flowRow(32'h38);
    expected[14] = flowRow(32'h40);
    expected[15] = wbRow(32'h48, 5'd31, 32'h4c);
    expected[16] = wbRow(32'h58, 5'd12, 32'hffffffff);
    expected[17] = flowRow(32'h5c);
    // write request to $0 still shows on the bus
    expected[18] = wbRow(32'h4c, 5'd0, 32'd7);
    expected[19] = wbRow(32'h50, 5'd11, 32'd6);
    expected[20] = flowRow(32'h54);
    expected[21] = flowRow(32'h54);
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic fieldError(input string field, input logic [31:0] got,
                            input logic [31:0] exp, input int row);
    abortRun($sformatf("error at %0t: row %0d field %s got %h expected %h",
                       $time, row, field, got, exp));
  endtask

  task automatic expectValid(input logic valid, input int row);
    if (valid !== 1'b1) begin
      abortRun($sformatf("commitValid was not high for row %0d at time %0t", row, $time));
    end
  endtask

  // address and data fields only matter when the matching write is on
  task automatic checkCommit(input commitT got, input commitT exp, input int row);
    if (got.pc !== exp.pc) fieldError("pc", got.pc, exp.pc, row);
    if (got.regWe !== exp.regWe) fieldError("regWe", 32'(got.regWe), 32'(exp.regWe), row);
    if (got.memWe !== exp.memWe) fieldError("memWe", 32'(got.memWe), 32'(exp.memWe), row);
    if (exp.regWe) begin
      if (got.regAddr !== exp.regAddr) begin
        fieldError("regAddr", 32'(got.regAddr), 32'(exp.regAddr), row);
      end
      if (got.regData !== exp.regData) fieldError("regData", got.regData, exp.regData, row);
    end
    if (exp.memWe) begin
      if (got.memAddr !== exp.memAddr) fieldError("memAddr", got.memAddr, exp.memAddr, row);
      if (got.memData !== exp.memData) fieldError("memData", got.memData, exp.memData, row);
    end
  endtask

  initial begin
    reset    = 1'b1;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    fillTables();
    // reset stays high through the load and the idle cycles after it
    for (int i = 0; i < PROG_LEN; i++) begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= 6'(i);
      progData <= prog[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
    repeat (RESET_IDLE - 1) @(posedge clk);
    reset <= 1'b0;
    // commit is sampled mid-cycle once it has settled
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(negedge clk);
      expectValid(commitValid, r);
      checkCommit(commit, expected[r], r);
    end
    $display("Done: no errors");
    $finish;
  end

  // a late load that must not replace the add at 0x50
  initial begin
    @(negedge reset);
    @(posedge clk);
    progWe   <= 1'b1;
    progAddr <= 6'd20;
    progData <= iType(`OP_ADDI, 5'd0, 5'd11, 16'd123);
    @(posedge clk);
    progWe <= 1'b0;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abortRun($sformatf("run timed out after %0d cycles", cycles));
    end
  end

endmodule

// ==== sim/mips_chk.sv ====
`timescale 1ns/1ps

module mipsChk (
  input logic        clk,
  input logic        reset,
  input logic [31:0] pc,
  input logic        wrEn,
  input logic        dmemWe,
  input logic        commitValid
);

  // fetch address stays on a word boundary
  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  quietInReset: assert property (@(posedge clk) reset |-> !wrEn && !dmemWe && !commitValid)
    else $error("write or commit active while reset is high");

  validAfterReset: assert property (@(posedge clk) !reset |-> commitValid)
    else $error("commitValid low after reset release");

endmodule

bind mipsCore mipsChk mipsChk_i (
  .clk         (clk),
  .reset       (reset),
  .pc          (pc),
  .wrEn        (wrEn),
  .dmemWe      (dmemWe),
  .commitValid (commitValid)
);

// ==== design/mipsTop.sv ====
`timescale 1ns/1ps

module mipsTop (
  input  logic            clk,
  input  logic            reset,
  input  logic            progWe,
  input  logic [5:0]      progAddr,
  input  mipsPkg::instrT  progData,
  output mipsPkg::commitT commit,
  output logic            commitValid
);
  import mipsPkg::*;

  instrT       imemData;
  logic [31:0] imemAddr;
  logic [4:0]  rdAddr1;
  logic [4:0]  rdAddr2;
  logic [31:0] rdData1;
  logic [31:0] rdData2;
  logic        wrEn;
  logic [4:0]  wrAddr;
  logic [31:0] wrData;
  logic [31:0] dmemAddr;
  logic        dmemWe;
  logic [31:0] dmemWrData;
  logic [31:0] dmemRdData;

  mipsCore mipsCore_i (
    .clk         (clk),
    .reset       (reset),
    .imemData    (imemData),
    .rdData1     (rdData1),
    .rdData2     (rdData2),
    .dmemRdData  (dmemRdData),
    .imemAddr    (imemAddr),
    .rdAddr1     (rdAddr1),
    .rdAddr2     (rdAddr2),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .dmemAddr    (dmemAddr),
    .dmemWe      (dmemWe),
    .dmemWrData  (dmemWrData),
    .commit      (commit),
    .commitValid (commitValid)
  );

  instrMem instrMem_i (
    .clk      (clk),
    .reset    (reset),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .addr     (imemAddr),
    .data     (imemData)
  );

  regFile regFile_i (
    .clk     (clk),
    .rdAddr1 (rdAddr1),
    .rdAddr2 (rdAddr2),
    .rdData1 (rdData1),
    .rdData2 (rdData2),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData)
  );

  dataMem dataMem_i (
    .clk    (clk),
    .we     (dmemWe),
    .addr   (dmemAddr),
    .wrData (dmemWrData),
    .rdData (dmemRdData)
  );

endmodule

// ==== design/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
  input  logic            clk,
  input  logic            reset,
  input  mipsPkg::instrT  imemData,
  input  logic [31:0]     rdData1,
  input  logic [31:0]     rdData2,
  input  logic [31:0]     dmemRdData,
  output logic [31:0]     imemAddr,
  output logic [4:0]      rdAddr1,
  output logic [4:0]      rdAddr2,
  output logic            wrEn,
  output logic [4:0]      wrAddr,
  output logic [31:0]     wrData,
  output logic [31:0]     dmemAddr,
  output logic            dmemWe,
  output logic [31:0]     dmemWrData,
  output mipsPkg::commitT commit,
  output logic            commitValid
);
  import mipsPkg::*;

  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [31:0] signImm;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic [31:0] result;
  logic [4:0]  destReg;
  logic        aluZero;
  logic        branchTaken;
  ctrlT        ctrl;

  mipsControl mipsControl_i (
    .instr (imemData),
    .ctrl  (ctrl)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= 32'd0;
    end else begin
      pc <= nextPc;
    end
  end

  assign imemAddr = pc;

  // field decode
  assign rdAddr1 = imemData.rFmt.rs;
  assign rdAddr2 = imemData.iFmt.rt;
  assign signImm = {{16{imemData.iFmt.imm[15]}}, imemData.iFmt.imm};

  // jal always links into $31
  assign destReg = ctrl.link   ? 5'd31 :
                   ctrl.regDst ? imemData.rFmt.rd : imemData.iFmt.rt;

  assign aluB = ctrl.aluSrc ? signImm : rdData2;

  mipsAlu mipsAlu_i (
    .a      (rdData1),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  assign result = ctrl.link     ? pcPlus4 :
                  ctrl.memToReg ? dmemRdData : aluResult;

  // next PC
  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], imemData.jFmt.target, 2'b00};
  assign branchTaken  = (ctrl.branchEq & aluZero) | (ctrl.branchNe & ~aluZero);

  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rdData1;
    end else if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // no writes while held in reset
  assign wrEn       = ctrl.regWrite & ~reset;
  assign wrAddr     = destReg;
  assign wrData     = result;
  assign dmemAddr   = aluResult;
  assign dmemWe     = ctrl.memWrite & ~reset;
  assign dmemWrData = rdData2;

  // record of what the coming edge writes
  assign commitValid     = ~reset;
  assign commit.pc       = pc;
  assign commit.regWe    = wrEn;
  assign commit.regAddr  = destReg;
  assign commit.regData  = result;
  assign commit.memWe    = dmemWe;
  assign commit.memAddr  = aluResult;
  assign commit.memData  = rdData2;

endmodule

// ==== design/dataMem.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module dataMem (
  input  logic        clk,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wrData,
  output logic [31:0] rdData
);

  logic [31:0] mem [0:`DMEM_WORDS-1];

  initial begin
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      mem[i] = 32'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr[7:2]] <= wrData;
    end
  end

  assign rdData = mem[addr[7:2]];

endmodule

// ==== design/instrMem.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module instrMem (
  input  logic           clk,
  input  logic           reset,
  input  logic           progWe,
  input  logic [5:0]     progAddr,
  input  mipsPkg::instrT progData,
  input  logic [31:0]    addr,
  output mipsPkg::instrT data
);

  logic [31:0] mem [0:`IMEM_WORDS-1];

  // program load is only honoured while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && progWe) begin
      mem[progAddr] <= progData;
    end
  end

  // byte address to word index
  assign data = mem[addr[7:2]];

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic [4:0]  rdAddr1,
  input  logic [4:0]  rdAddr2,
  output logic [31:0] rdData1,
  output logic [31:0] rdData2,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData
);

  logic [31:0] regs [31:0];

  // writes to $0 are dropped
  always_ff @(posedge clk) begin
    if (wrEn && wrAddr != 5'd0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // $0 reads as zero regardless of array contents
  assign rdData1 = (rdAddr1 == 5'd0) ? 32'd0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == 5'd0) ? 32'd0 : regs[rdAddr2];

endmodule

// ==== design/mipsAlu.sv ====
`timescale 1ns/1ps

module mipsAlu (
  input  logic [31:0]   a,
  input  logic [31:0]   b,
  input  mipsPkg::aluOpT op,
  output logic [31:0]   result,
  output logic          zero
);
  import mipsPkg::*;

  always_comb begin
    case (op)
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      // signed compare
      aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
      default: result = '0;
    endcase
  end

  // drives the beq/bne decision
  assign zero = (result == 32'd0);

endmodule

// ==== design/mipsControl.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsControl (
  input  mipsPkg::instrT instr,
  output mipsPkg::ctrlT  ctrl
);
  import mipsPkg::*;

  always_comb begin
    // everything inactive unless an opcode below says otherwise
    ctrl = '0;
    case (instr.rFmt.opcode)
      `OP_RTYPE: begin
        case (instr.rFmt.funct)
          `FN_ADD: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAdd;
          end
          `FN_SUB: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSub;
          end
          `FN_AND: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAnd;
          end
          `FN_OR: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluOr;
          end
          `FN_SLT: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSlt;
          end
          // jr only redirects the PC
          `FN_JR:  ctrl.jumpReg = 1'b1;
          default: ctrl = '0;
        endcase
      end
      `OP_ADDI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      `OP_LW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      `OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      `OP_BEQ: begin
        ctrl.branchEq = 1'b1;
        ctrl.aluOp    = aluSub;
      end
      `OP_BNE: begin
        ctrl.branchNe = 1'b1;
        ctrl.aluOp    = aluSub;
      end
      `OP_J:   ctrl.jump = 1'b1;
      `OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== design/mipsPkg.sv ====
package mipsPkg;

  // ALU operation select
  typedef enum logic [2:0] {
    aluAnd = 3'd0,
    aluOr  = 3'd1,
    aluAdd = 3'd2,
    aluSub = 3'd6,
    aluSlt = 3'd7
  } aluOpT;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFmtT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFmtT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFmtT;

  // one instruction word seen through three views
  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    jFmtT jFmt;
  } instrT;

  typedef struct packed {
    logic  memToReg;
    logic  memWrite;
    logic  branchNe;
    logic  branchEq;
    logic  aluSrc;
    logic  regDst;
    logic  regWrite;
    logic  jump;
    logic  link;
    logic  jumpReg;
    aluOpT aluOp;
  } ctrlT;

  // write activity of one retired instruction
  typedef struct packed {
    logic [31:0] pc;
    logic        regWe;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memData;
  } commitT;

endpackage

// ==== design/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes for R-type
`define FN_JR    6'h08
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_SLT   6'h2a

`endif
